//--- build.f
cmd_parse_pkg.sv
glob_cmd_unit.sv
chan_cfg_regs.sv
fifo_wr_route.sv
fifo_rd_route.sv
cmd_parse.sv
tb_clk_gen.sv
tb_cmd_parse.sv

//--- chan_cfg_regs.sv
`timescale 1ns/1ps

module chan_cfg_regs #(
	parameter int n_ch = 11
) (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic [cmd_parse_pkg::reg_bits-1:0]                   sub_cmd,
	input  logic [cmd_parse_pkg::ch_bits-1:0]                    sub_cmd_addr,
	input  logic [cmd_parse_pkg::data_width-1:0]                 sub_cmd_data,
	input  logic                                                 sub_cmd_en,
	input  logic                                                 sub_cmd_fb_en,
	input  logic [n_ch-1:0][cmd_parse_pkg::state_width-1:0]      uart_state,
	input  logic [n_ch-1:0]                                      chan_rd_empty,
	output logic [n_ch-1:0]                                      rx_en,
	output logic [n_ch-1:0]                                      tx_en,
	output logic [n_ch-1:0][cmd_parse_pkg::data_width-1:0]       bps,
	output logic [n_ch-1:0]                                      stop_bit,
	output logic [n_ch-1:0]                                      csum_en,
	output logic [n_ch-1:0][1:0]                                 csum_mode,
	output logic [cmd_parse_pkg::data_width-1:0]                 sub_cmd_fb_data
);

	localparam logic [cmd_parse_pkg::ch_bits:0] n_ch_lim = (cmd_parse_pkg::ch_bits + 1)'(n_ch);

	// four register bytes per channel
	cmd_parse_pkg::cfg_word_u regs [n_ch][4];
	cmd_parse_pkg::cfg_word_u cur;
	logic                     in_range;

	assign in_range = ({1'b0, sub_cmd_addr} < n_ch_lim);
	assign cur      = regs[sub_cmd_addr][sub_cmd];

	// ====================
	// host writes
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int c = 0; c < n_ch; c++) begin
				for (int r = 0; r < 4; r++) begin
					regs[c][r].raw <= '0;
				end
			end
		end else if (sub_cmd_en && in_range) begin
			regs[sub_cmd_addr][sub_cmd].raw <= sub_cmd_data;
		end
	end

	// ====================
	// readback
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sub_cmd_fb_data <= '0;
		end else if (sub_cmd_fb_en) begin
			if (!in_range) begin
				sub_cmd_fb_data <= '0;
			end else begin
				case (sub_cmd)
					// status: rx data pending, live uart state, stored enables
					cmd_parse_pkg::reg_ctrl: begin
						sub_cmd_fb_data <= {~chan_rd_empty[sub_cmd_addr],
						                    uart_state[sub_cmd_addr],
						                    cur.ctrl.tx_en,
						                    cur.ctrl.rx_en};
					end
					cmd_parse_pkg::reg_bps,
					cmd_parse_pkg::reg_frame,
					cmd_parse_pkg::reg_spare: begin
						sub_cmd_fb_data <= cur.raw;
					end
				endcase
			end
		end
	end

	// ====================
	// config outputs
	// ====================
	for (genvar ch = 0; ch < n_ch; ch++) begin : g_decode
		assign rx_en[ch]     = regs[ch][cmd_parse_pkg::reg_ctrl].ctrl.rx_en;
		assign tx_en[ch]     = regs[ch][cmd_parse_pkg::reg_ctrl].ctrl.tx_en;
		assign bps[ch]       = regs[ch][cmd_parse_pkg::reg_bps].raw;
		assign stop_bit[ch]  = regs[ch][cmd_parse_pkg::reg_frame].frame.stop_bit;
		assign csum_en[ch]   = regs[ch][cmd_parse_pkg::reg_frame].frame.csum_en;
		assign csum_mode[ch] = regs[ch][cmd_parse_pkg::reg_frame].frame.csum_mode;
	end

	// address lines are shared, so a write and a read together always collide
	a_no_same_addr: assert property (
		@(posedge clk) disable iff (!rst_n)
		sub_cmd_en |-> !sub_cmd_fb_en
	) else $error("channel register write and read hit the same address");

endmodule

//--- cmd_parse.sv
`timescale 1ns/1ps

module cmd_parse #(
	parameter int n_ch = 11
) (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	// ====================
	// global commands
	// ====================
	input  logic [2:0]                                           glob_cmd,
	input  logic [cmd_parse_pkg::glob_width-1:0]                 glob_cmd_data,
	input  logic                                                 glob_cmd_en,
	input  logic                                                 glob_cmd_fb_en,
	output logic [cmd_parse_pkg::glob_width-1:0]                 glob_cmd_fb_data,
	output logic                                                 glob_irq,
	// ====================
	// channel commands
	// ====================
	input  logic [cmd_parse_pkg::reg_bits-1:0]                   sub_cmd,
	input  logic [cmd_parse_pkg::ch_bits-1:0]                    sub_cmd_addr,
	input  logic [cmd_parse_pkg::data_width-1:0]                 sub_cmd_data,
	input  logic                                                 sub_cmd_en,
	input  logic                                                 sub_cmd_fb_en,
	output logic [cmd_parse_pkg::data_width-1:0]                 sub_cmd_fb_data,
	// ====================
	// host fifo port
	// ====================
	input  logic [cmd_parse_pkg::ch_bits-1:0]                    fifo_wr_addr,
	input  logic [cmd_parse_pkg::data_width-1:0]                 fifo_wr_data,
	input  logic                                                 fifo_wr_en,
	output logic                                                 fifo_wr_full,
	input  logic [cmd_parse_pkg::ch_bits-1:0]                    fifo_rd_addr,
	input  logic                                                 fifo_rd_en,
	output logic [cmd_parse_pkg::data_width-1:0]                 fifo_rd_data,
	output logic                                                 fifo_rd_empty,
	// ====================
	// uart channels
	// ====================
	input  logic [n_ch-1:0]                                      iq,
	input  logic [n_ch-1:0][cmd_parse_pkg::state_width-1:0]      uart_state,
	input  logic [n_ch-1:0]                                      chan_wr_full,
	input  logic [n_ch-1:0]                                      chan_rd_empty,
	input  logic [n_ch-1:0][cmd_parse_pkg::data_width-1:0]       chan_rd_data,
	output logic [n_ch-1:0]                                      iq_en,
	output logic [n_ch-1:0]                                      chan_rst,
	output logic [n_ch-1:0]                                      rx_en,
	output logic [n_ch-1:0]                                      tx_en,
	output logic [n_ch-1:0][cmd_parse_pkg::data_width-1:0]       bps,
	output logic [n_ch-1:0]                                      stop_bit,
	output logic [n_ch-1:0]                                      csum_en,
	output logic [n_ch-1:0][1:0]                                 csum_mode,
	output logic [n_ch-1:0]                                      chan_wr_en,
	output logic [n_ch-1:0]                                      chan_rd_en,
	output logic [cmd_parse_pkg::data_width-1:0]                 chan_wr_data
);

	glob_cmd_unit #(.n_ch(n_ch)) i_glob_cmd_unit (
		.clk, .rst_n, .glob_cmd, .glob_cmd_data, .glob_cmd_en, .glob_cmd_fb_en,
		.iq, .iq_en, .chan_rst, .glob_cmd_fb_data, .glob_irq
	);

	chan_cfg_regs #(.n_ch(n_ch)) i_chan_cfg_regs (
		.clk, .rst_n, .sub_cmd, .sub_cmd_addr, .sub_cmd_data, .sub_cmd_en,
		.sub_cmd_fb_en, .uart_state, .chan_rd_empty, .rx_en, .tx_en, .bps,
		.stop_bit, .csum_en, .csum_mode, .sub_cmd_fb_data
	);

	fifo_wr_route #(.n_ch(n_ch)) i_fifo_wr_route (
		.clk, .rst_n, .fifo_wr_addr, .fifo_wr_data, .fifo_wr_en, .chan_wr_full,
		.chan_wr_en, .chan_wr_data, .fifo_wr_full
	);

	fifo_rd_route #(.n_ch(n_ch)) i_fifo_rd_route (
		.clk, .rst_n, .fifo_rd_addr, .fifo_rd_en, .chan_rd_data, .chan_rd_empty,
		.chan_rd_en, .fifo_rd_data, .fifo_rd_empty
	);

endmodule

//--- cmd_parse_pkg.sv
package cmd_parse_pkg;

	// ====================
	// field widths
	// ====================
	localparam int data_width  = 8;
	localparam int ch_bits     = 4;
	localparam int reg_bits    = 2;
	localparam int glob_width  = 11;
	localparam int state_width = 5;

	// global command codes
	typedef enum logic [2:0] {
		gc_irq_en   = 3'd0,
		gc_irq_stat = 3'd1,
		gc_restart  = 3'd2
	} glob_cmd_t;

	// fixed bits, then major.minor.revision
	localparam logic [glob_width-1:0] version_word = {2'b10, 3'd1, 3'd0, 3'd0};

	// ====================
	// per-channel register map
	// ====================
	localparam logic [reg_bits-1:0] reg_ctrl  = 2'd0;
	localparam logic [reg_bits-1:0] reg_bps   = 2'd1;
	localparam logic [reg_bits-1:0] reg_frame = 2'd2;
	localparam logic [reg_bits-1:0] reg_spare = 2'd3;

	typedef struct packed {
		logic [5:0] rsvd;
		logic       tx_en;
		logic       rx_en;
	} ctrl_bits_t;

	typedef struct packed {
		logic       stop_bit;
		logic       csum_en;
		logic [1:0] csum_mode;
		logic [3:0] rsvd;
	} frame_bits_t;

	// one register byte, seen through the view its offset calls for
	typedef union packed {
		logic [data_width-1:0] raw;
		ctrl_bits_t            ctrl;
		frame_bits_t           frame;
	} cfg_word_u;

endpackage

//--- fifo_rd_route.sv
`timescale 1ns/1ps

module fifo_rd_route #(
	parameter int n_ch = 11
) (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  logic [cmd_parse_pkg::ch_bits-1:0]                fifo_rd_addr,
	input  logic                                             fifo_rd_en,
	input  logic [n_ch-1:0][cmd_parse_pkg::data_width-1:0]   chan_rd_data,
	input  logic [n_ch-1:0]                                  chan_rd_empty,
	output logic [n_ch-1:0]                                  chan_rd_en,
	output logic [cmd_parse_pkg::data_width-1:0]             fifo_rd_data,
	output logic                                             fifo_rd_empty
);

	localparam logic [cmd_parse_pkg::ch_bits:0] n_ch_lim = (cmd_parse_pkg::ch_bits + 1)'(n_ch);

	logic            in_range;
	logic [n_ch-1:0] rd_sel;
	logic [1:0]      empty_pipe;

	assign in_range = ({1'b0, fifo_rd_addr} < n_ch_lim);

	always_comb begin
		rd_sel = '0;
		if (fifo_rd_en && in_range) begin
			rd_sel[fifo_rd_addr] = 1'b1;
		end
	end

	// ====================
	// strobe and empty flag
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chan_rd_en <= '0;
			empty_pipe <= 2'b11;
		end else begin
			chan_rd_en <= rd_sel;
			if (in_range) begin
				empty_pipe[0] <= chan_rd_empty[fifo_rd_addr];
			end
			empty_pipe[1] <= empty_pipe[0];
		end
	end

	assign fifo_rd_empty = empty_pipe[1];

	// read byte of the selected channel, one cycle behind the address
	always_ff @(posedge clk) begin
		if (in_range) begin
			fifo_rd_data <= chan_rd_data[fifo_rd_addr];
		end
	end

	a_rd_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(chan_rd_en)
	) else $error("more than one channel read strobe active");

endmodule

//--- fifo_wr_route.sv
`timescale 1ns/1ps

module fifo_wr_route #(
	parameter int n_ch = 11
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [cmd_parse_pkg::ch_bits-1:0]      fifo_wr_addr,
	input  logic [cmd_parse_pkg::data_width-1:0]   fifo_wr_data,
	input  logic                                   fifo_wr_en,
	input  logic [n_ch-1:0]                        chan_wr_full,
	output logic [n_ch-1:0]                        chan_wr_en,
	output logic [cmd_parse_pkg::data_width-1:0]   chan_wr_data,
	output logic                                   fifo_wr_full
);

	localparam logic [cmd_parse_pkg::ch_bits:0] n_ch_lim = (cmd_parse_pkg::ch_bits + 1)'(n_ch);

	logic            in_range;
	logic [n_ch-1:0] wr_sel;

	assign in_range = ({1'b0, fifo_wr_addr} < n_ch_lim);

	// one-hot channel strobe
	always_comb begin
		wr_sel = '0;
		if (fifo_wr_en && in_range) begin
			wr_sel[fifo_wr_addr] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chan_wr_en   <= '0;
			fifo_wr_full <= 1'b0;
		end else begin
			chan_wr_en <= wr_sel;
			// unknown channel keeps the last reported flag
			if (in_range) begin
				fifo_wr_full <= chan_wr_full[fifo_wr_addr];
			end
		end
	end

	// shared byte bus, lines up with the strobe
	always_ff @(posedge clk) begin
		chan_wr_data <= fifo_wr_data;
	end

	a_wr_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(chan_wr_en)
	) else $error("more than one channel write strobe active");

endmodule

//--- glob_cmd_unit.sv
`timescale 1ns/1ps

module glob_cmd_unit #(
	parameter int n_ch = 11
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [2:0]                             glob_cmd,
	input  logic [cmd_parse_pkg::glob_width-1:0]   glob_cmd_data,
	input  logic                                   glob_cmd_en,
	input  logic                                   glob_cmd_fb_en,
	input  logic [n_ch-1:0]                        iq,
	output logic [n_ch-1:0]                        iq_en,
	output logic [n_ch-1:0]                        chan_rst,
	output logic [cmd_parse_pkg::glob_width-1:0]   glob_cmd_fb_data,
	output logic                                   glob_irq
);

	localparam int ext_width = n_ch + cmd_parse_pkg::glob_width;

	cmd_parse_pkg::glob_cmd_t cmd;
	logic [ext_width-1:0]     data_ext;
	logic [ext_width-1:0]     en_ext;
	logic [ext_width-1:0]     iq_ext;
	logic                     irq_any;

	assign cmd = cmd_parse_pkg::glob_cmd_t'(glob_cmd);

	// zero-extend so any channel count lines up with the 11-bit command word
	assign data_ext = {{n_ch{1'b0}}, glob_cmd_data};
	assign en_ext   = {{cmd_parse_pkg::glob_width{1'b0}}, iq_en};
	assign iq_ext   = {{cmd_parse_pkg::glob_width{1'b0}}, iq};

	// ====================
	// command writes
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			iq_en    <= '0;
			chan_rst <= '0;
		end else if (glob_cmd_en) begin
			if (cmd == cmd_parse_pkg::gc_irq_en) begin
				iq_en <= data_ext[n_ch-1:0];
			end
			// reset mask holds until the next global command of any kind
			if (cmd == cmd_parse_pkg::gc_restart) begin
				chan_rst <= data_ext[n_ch-1:0];
			end else begin
				chan_rst <= '0;
			end
		end
	end

	// ====================
	// feedback reads
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			glob_cmd_fb_data <= '0;
		end else if (glob_cmd_fb_en) begin
			case (cmd)
				cmd_parse_pkg::gc_irq_en:   glob_cmd_fb_data <= en_ext[cmd_parse_pkg::glob_width-1:0];
				cmd_parse_pkg::gc_irq_stat: glob_cmd_fb_data <= iq_ext[cmd_parse_pkg::glob_width-1:0];
				cmd_parse_pkg::gc_restart:  glob_cmd_fb_data <= cmd_parse_pkg::version_word;
				default:                    glob_cmd_fb_data <= '0;
			endcase
		end
	end

	// raw levels only, enables are not applied here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_any <= 1'b0;
		end else begin
			irq_any <= |iq;
		end
	end

	// active low toward the host
	assign glob_irq = ~irq_any;

	// host never issues a write and a readback in one cycle
	a_no_wr_rd_overlap: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(glob_cmd_en && glob_cmd_fb_en)
	) else $error("global write and feedback request in the same cycle");

endmodule

//--- run.sh
#!/bin/sh
# build and run the cmd_parse testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_cmd_parse -f build.f
out=$(./obj_dir/Vtb_cmd_parse)
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int period_ns = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

//--- tb_cmd_parse.sv
`timescale 1ns/1ps

module tb_cmd_parse;

	localparam int          n_ch       = 11;
	localparam logic [4:0]  ch_limit   = 5'd11;
	// stimulus below takes roughly 400 cycles
	localparam int          max_cycles = 2000;
	localparam logic [31:0] seed       = 32'hd533_8a21;

	logic                  clk;
	logic                  rst_n;
	logic [2:0]            glob_cmd;
	logic [10:0]           glob_cmd_data;
	logic                  glob_cmd_en;
	logic                  glob_cmd_fb_en;
	logic [10:0]           glob_cmd_fb_data;
	logic                  glob_irq;
	logic [1:0]            sub_cmd;
	logic [3:0]            sub_cmd_addr;
	logic [7:0]            sub_cmd_data;
	logic                  sub_cmd_en;
	logic                  sub_cmd_fb_en;
	logic [7:0]            sub_cmd_fb_data;
	logic [3:0]            fifo_wr_addr;
	logic [7:0]            fifo_wr_data;
	logic                  fifo_wr_en;
	logic                  fifo_wr_full;
	logic [3:0]            fifo_rd_addr;
	logic                  fifo_rd_en;
	logic [7:0]            fifo_rd_data;
	logic                  fifo_rd_empty;
	logic [n_ch-1:0]       iq;
	logic [n_ch-1:0][4:0]  uart_state;
	logic [n_ch-1:0]       chan_wr_full;
	logic [n_ch-1:0]       chan_rd_empty;
	logic [n_ch-1:0][7:0]  chan_rd_data;
	logic [n_ch-1:0]       iq_en;
	logic [n_ch-1:0]       chan_rst;
	logic [n_ch-1:0]       rx_en;
	logic [n_ch-1:0]       tx_en;
	logic [n_ch-1:0][7:0]  bps;
	logic [n_ch-1:0]       stop_bit;
	logic [n_ch-1:0]       csum_en;
	logic [n_ch-1:0][1:0]  csum_mode;
	logic [n_ch-1:0]       chan_wr_en;
	logic [n_ch-1:0]       chan_rd_en;
	logic [7:0]            chan_wr_data;

	logic [31:0] cmd_rnd;
	logic [31:0] side_rnd;
	int          errors = 0;
	int          cycles = 0;

	tb_clk_gen #(.period_ns(8)) i_clk_gen (.clk);

	cmd_parse #(.n_ch(n_ch)) i_cmd_parse (.*);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic valid_ch(input logic [3:0] ch);
		return {1'b0, ch} < ch_limit;
	endfunction

	function automatic logic [n_ch-1:0] channel_strobe(input logic en, input logic [3:0] ch);
		logic [n_ch-1:0] v;
		v = '0;
		if (en && valid_ch(ch)) begin
			v[ch] = 1'b1;
		end
		return v;
	endfunction

	// ====================
	// reference model
	// ====================
	logic [n_ch-1:0]      m_iq_en;
	logic [n_ch-1:0]      m_chan_rst;
	logic [10:0]          m_glob_fb;
	logic                 m_glob_irq;
	logic [7:0]           m_regs [n_ch][4];
	logic [7:0]           m_sub_fb;
	logic [n_ch-1:0]      m_wr_en;
	logic [7:0]           m_wr_data;
	logic                 m_wr_full;
	logic [n_ch-1:0]      m_rd_en;
	logic [7:0]           m_rd_data;
	logic [1:0]           m_empty;
	logic [n_ch-1:0]      exp_rx_en;
	logic [n_ch-1:0]      exp_tx_en;
	logic [n_ch-1:0][7:0] exp_bps;
	logic [n_ch-1:0]      exp_stop_bit;
	logic [n_ch-1:0]      exp_csum_en;
	logic [n_ch-1:0][1:0] exp_csum_mode;

	// status word for offset 0, stored byte otherwise
	function automatic logic [7:0] reg_readback(input logic [3:0] ch, input logic [1:0] off);
		if (!valid_ch(ch)) begin
			return '0;
		end
		if (off == cmd_parse_pkg::reg_ctrl) begin
			return {~chan_rd_empty[ch], uart_state[ch], m_regs[ch][0][1:0]};
		end
		return m_regs[ch][off];
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			m_iq_en    <= '0;
			m_chan_rst <= '0;
			m_glob_fb  <= '0;
			m_glob_irq <= 1'b1;
			m_sub_fb   <= '0;
			m_wr_en    <= '0;
			m_wr_full  <= 1'b0;
			m_rd_en    <= '0;
			m_empty    <= 2'b11;
			for (int c = 0; c < n_ch; c++) begin
				for (int r = 0; r < 4; r++) begin
					m_regs[c][r] <= '0;
				end
			end
		end else begin
			if (glob_cmd_en) begin
				if (glob_cmd == cmd_parse_pkg::gc_irq_en) begin
					m_iq_en <= glob_cmd_data;
				end
				m_chan_rst <= (glob_cmd == cmd_parse_pkg::gc_restart) ? glob_cmd_data : '0;
			end
			if (glob_cmd_fb_en) begin
				case (glob_cmd)
					cmd_parse_pkg::gc_irq_en:   m_glob_fb <= m_iq_en;
					cmd_parse_pkg::gc_irq_stat: m_glob_fb <= iq;
					cmd_parse_pkg::gc_restart:  m_glob_fb <= {2'b10, 3'd1, 3'd0, 3'd0};
					default:                    m_glob_fb <= '0;
				endcase
			end
			m_glob_irq <= (iq == '0);
			if (sub_cmd_en && valid_ch(sub_cmd_addr)) begin
				m_regs[sub_cmd_addr][sub_cmd] <= sub_cmd_data;
			end
			if (sub_cmd_fb_en) begin
				m_sub_fb <= reg_readback(sub_cmd_addr, sub_cmd);
			end
			m_wr_en <= channel_strobe(fifo_wr_en, fifo_wr_addr);
			m_rd_en <= channel_strobe(fifo_rd_en, fifo_rd_addr);
			if (valid_ch(fifo_wr_addr)) begin
				m_wr_full <= chan_wr_full[fifo_wr_addr];
			end
			if (valid_ch(fifo_rd_addr)) begin
				m_empty[0] <= chan_rd_empty[fifo_rd_addr];
			end
			m_empty[1] <= m_empty[0];
		end
	end

	// byte paths carry no reset
	always @(posedge clk) begin
		m_wr_data <= fifo_wr_data;
		if (valid_ch(fifo_rd_addr)) begin
			m_rd_data <= chan_rd_data[fifo_rd_addr];
		end
	end

	// ctrl: rx_en bit 0, tx_en bit 1; frame: stop 7, csum_en 6, mode 5:4
	always_comb begin
		for (int c = 0; c < n_ch; c++) begin
			exp_rx_en[c]     = m_regs[c][0][0];
			exp_tx_en[c]     = m_regs[c][0][1];
			exp_bps[c]       = m_regs[c][1];
			exp_stop_bit[c]  = m_regs[c][2][7];
			exp_csum_en[c]   = m_regs[c][2][6];
			exp_csum_mode[c] = m_regs[c][2][5:4];
		end
	end

	// ====================
	// checks
	// ====================
	task automatic flag_mismatch(input string what);
		errors++;
		$display("ERR %0t: %s does not match the expected value", $time, what);
	endtask

	a_reset_values: assert property (@(posedge clk) $rose(rst_n) |->
		glob_irq && fifo_rd_empty && !fifo_wr_full && iq_en == '0 && chan_rst == '0
		&& chan_wr_en == '0 && chan_rd_en == '0 && rx_en == '0 && tx_en == '0
		&& bps == '0 && stop_bit == '0 && csum_en == '0 && csum_mode == '0
		&& glob_cmd_fb_data == '0 && sub_cmd_fb_data == '0)
		else flag_mismatch("state right after reset");

	a_iq_en: assert property (@(posedge clk) disable iff (!rst_n) iq_en == m_iq_en)
		else flag_mismatch("iq_en");
	a_chan_rst: assert property (@(posedge clk) disable iff (!rst_n) chan_rst == m_chan_rst)
		else flag_mismatch("chan_rst");
	a_glob_fb: assert property (@(posedge clk) disable iff (!rst_n)
		glob_cmd_fb_data == m_glob_fb) else flag_mismatch("glob_cmd_fb_data");
	a_glob_irq: assert property (@(posedge clk) disable iff (!rst_n) glob_irq == m_glob_irq)
		else flag_mismatch("glob_irq");
	a_ctrl_out: assert property (@(posedge clk) disable iff (!rst_n)
		rx_en == exp_rx_en && tx_en == exp_tx_en) else flag_mismatch("rx_en or tx_en");
	a_bps_out: assert property (@(posedge clk) disable iff (!rst_n) bps == exp_bps)
		else flag_mismatch("bps");
	a_frame_out: assert property (@(posedge clk) disable iff (!rst_n)
		stop_bit == exp_stop_bit && csum_en == exp_csum_en && csum_mode == exp_csum_mode)
		else flag_mismatch("frame settings");
	a_sub_fb: assert property (@(posedge clk) disable iff (!rst_n)
		sub_cmd_fb_data == m_sub_fb) else flag_mismatch("sub_cmd_fb_data");
	a_wr_en: assert property (@(posedge clk) disable iff (!rst_n) chan_wr_en == m_wr_en)
		else flag_mismatch("chan_wr_en");
	a_wr_data: assert property (@(posedge clk) disable iff (!rst_n) chan_wr_data == m_wr_data)
		else flag_mismatch("chan_wr_data");
	a_wr_full: assert property (@(posedge clk) disable iff (!rst_n) fifo_wr_full == m_wr_full)
		else flag_mismatch("fifo_wr_full");
	a_rd_en: assert property (@(posedge clk) disable iff (!rst_n) chan_rd_en == m_rd_en)
		else flag_mismatch("chan_rd_en");
	a_rd_data: assert property (@(posedge clk) disable iff (!rst_n) fifo_rd_data == m_rd_data)
		else flag_mismatch("fifo_rd_data");
	a_rd_empty: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_rd_empty == m_empty[1]) else flag_mismatch("fifo_rd_empty");

	// ====================
	// stimulus
	// ====================
	// free-running channel side, iq quiet about a quarter of the time
	always @(posedge clk) begin
		side_rnd = lcg_step(side_rnd);
		iq           <= (side_rnd[31:30] == 2'b00) ? '0 : side_rnd[10:0];
		chan_wr_full <= side_rnd[21:11];
		side_rnd = lcg_step(side_rnd);
		chan_rd_empty <= side_rnd[20:10];
		for (int c = 0; c < n_ch; c++) begin
			side_rnd = lcg_step(side_rnd);
			uart_state[c]   <= side_rnd[20:16];
			chan_rd_data[c] <= side_rnd[31:24];
		end
	end

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic glob_write(input logic [2:0] code, input logic [10:0] data);
		@(posedge clk);
		glob_cmd      <= code;
		glob_cmd_data <= data;
		glob_cmd_en   <= 1'b1;
		@(posedge clk);
		glob_cmd_en <= 1'b0;
	endtask

	task automatic glob_read(input logic [2:0] code);
		@(posedge clk);
		glob_cmd       <= code;
		glob_cmd_fb_en <= 1'b1;
		@(posedge clk);
		glob_cmd_fb_en <= 1'b0;
	endtask

	task automatic chan_write(input logic [3:0] ch, input logic [1:0] off, input logic [7:0] d);
		@(posedge clk);
		sub_cmd_addr <= ch;
		sub_cmd      <= off;
		sub_cmd_data <= d;
		sub_cmd_en   <= 1'b1;
		@(posedge clk);
		sub_cmd_en <= 1'b0;
	endtask

	task automatic chan_read(input logic [3:0] ch, input logic [1:0] off);
		@(posedge clk);
		sub_cmd_addr  <= ch;
		sub_cmd       <= off;
		sub_cmd_fb_en <= 1'b1;
		@(posedge clk);
		sub_cmd_fb_en <= 1'b0;
	endtask

	task automatic run_global_cmds();
		for (int i = 0; i < 6; i++) begin
			cmd_rnd = lcg_step(cmd_rnd);
			glob_write(cmd_parse_pkg::gc_irq_en, cmd_rnd[10:0]);
			glob_read(cmd_parse_pkg::gc_irq_en);
			glob_read(cmd_parse_pkg::gc_irq_stat);
			glob_read(cmd_parse_pkg::gc_restart);
			glob_write(cmd_parse_pkg::gc_restart, cmd_rnd[26:16]);
			idle(2);
			// another code drops the mask again
			glob_write(cmd_parse_pkg::gc_irq_stat, 11'h7ff);
			glob_read(3'd5);
		end
	endtask

	task automatic run_chan_regs();
		for (int c = 0; c < n_ch; c++) begin
			for (int r = 0; r < 4; r++) begin
				cmd_rnd = lcg_step(cmd_rnd);
				chan_write(4'(c), 2'(r), cmd_rnd[31:24]);
			end
		end
		for (int c = 0; c < n_ch; c++) begin
			for (int r = 0; r < 4; r++) begin
				chan_read(4'(c), 2'(r));
			end
		end
		// random channels, 11 to 15 included
		for (int i = 0; i < 16; i++) begin
			cmd_rnd = lcg_step(cmd_rnd);
			chan_write(cmd_rnd[19:16], cmd_rnd[21:20], cmd_rnd[31:24]);
			chan_read(cmd_rnd[19:16], cmd_rnd[21:20]);
		end
		chan_write(4'd13, cmd_parse_pkg::reg_bps, 8'hff);
		chan_read(4'd13, cmd_parse_pkg::reg_bps);
		chan_read(4'd15, cmd_parse_pkg::reg_ctrl);
	endtask

	task automatic run_fifo_traffic();
		for (int i = 0; i < 40; i++) begin
			cmd_rnd = lcg_step(cmd_rnd);
			@(posedge clk);
			fifo_wr_en   <= cmd_rnd[30] || cmd_rnd[28];
			fifo_wr_addr <= cmd_rnd[19:16];
			fifo_wr_data <= cmd_rnd[31:24];
			fifo_rd_en   <= cmd_rnd[29] || cmd_rnd[27];
			fifo_rd_addr <= cmd_rnd[23:20];
		end
		@(posedge clk);
		fifo_wr_en <= 1'b0;
		fifo_rd_en <= 1'b0;
		idle(3);
	endtask

	initial begin
		rst_n          = 1'b0;
		glob_cmd       = '0;
		glob_cmd_data  = '0;
		glob_cmd_en    = 1'b0;
		glob_cmd_fb_en = 1'b0;
		sub_cmd        = '0;
		sub_cmd_addr   = '0;
		sub_cmd_data   = '0;
		sub_cmd_en     = 1'b0;
		sub_cmd_fb_en  = 1'b0;
		fifo_wr_addr   = '0;
		fifo_wr_data   = '0;
		fifo_wr_en     = 1'b0;
		fifo_rd_addr   = '0;
		fifo_rd_en     = 1'b0;
		iq             = '0;
		uart_state     = '0;
		chan_wr_full   = '0;
		chan_rd_empty  = '1;
		chan_rd_data   = '0;
		cmd_rnd        = seed;
		side_rnd       = seed ^ 32'h9e37_79b9;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		idle(1);
		run_global_cmds();
		run_chan_regs();
		run_fifo_traffic();
		idle(4);
		$display("run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: stimulus still running after %0d cycles", max_cycles);
			$display("Test FAILED");
			$finish;
		end
	end

endmodule
